//--- logic/bridge_master.sv
/*
  Turns single bridge read/write pulses into Wishbone classic cycles.
  Busy for three edges per request. A request arriving while busy is dropped,
  so the host has to space requests at least four cycles apart.
*/
`timescale 1ns/1ps
`default_nettype none

module bridge_master (
  input  wire                         clk_74a,
  input  wire                         pll_core_locked,
  input  wire core_pkg::bridge_addr_t bridge_addr,
  input  wire                         bridge_rd,
  input  wire                         bridge_wr,
  input  wire core_pkg::bridge_data_t bridge_wr_data,
  output core_pkg::bridge_data_t      bridge_rd_data,
  wb_if.master                        bus
);

  core_pkg::wb_state_t    state;
  core_pkg::bridge_addr_t req_addr;
  core_pkg::bridge_data_t req_data;
  logic                   req_we;
  logic                   req_accept;

  // only picked up while idle
  assign req_accept = (state == core_pkg::wb_idle) && (bridge_rd || bridge_wr);

  ////////////////////
  // FSM and read data

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      state          <= core_pkg::wb_idle;
      bridge_rd_data <= '0;
    end else begin
      case (state)
        core_pkg::wb_idle: begin
          if (req_accept) begin
            state <= core_pkg::wb_cycle;
          end
        end
        core_pkg::wb_cycle: begin
          // slave answers with a single-cycle ack
          if (bus.ack) begin
            state <= core_pkg::wb_idle;
            if (!req_we) begin
              bridge_rd_data <= bus.dat_r;
            end
          end
        end
        default: state <= core_pkg::wb_idle;
      endcase
    end
  end

  ////////////////////
  // request latch

  always_ff @(posedge clk_74a) begin
    if (req_accept) begin
      req_addr <= bridge_addr;
      req_data <= bridge_wr_data;
      // write wins if both pulses come together
      req_we   <= bridge_wr;
    end
  end

  // address and data stay constant for the whole cycle
  assign bus.cyc   = (state == core_pkg::wb_cycle);
  assign bus.stb   = (state == core_pkg::wb_cycle);
  assign bus.we    = req_we;
  assign bus.adr   = req_addr;
  assign bus.dat_w = req_data;

endmodule

`default_nettype wire

//--- logic/core_pkg.sv
/*
  Shared widths, types and the settings register map of the core.
  Addresses are bridge byte addresses and are decoded as full 32-bit words.
  Timing constants are small so that simulation stays short.
*/
`default_nettype none

package core_pkg;

  // bridge and bus words
  typedef logic [31:0] bridge_addr_t;
  typedef logic [31:0] bridge_data_t;

  // video path
  typedef logic [23:0] rgb_t;
  typedef logic [2:0]  hs_count_t;

  // settings fields
  typedef logic [1:0]  edge_mask_t;
  typedef logic [2:0]  palette_t;
  typedef logic [7:0]  aim_speed_t;
  typedef logic [6:0]  reset_count_t;

  // bridge master FSM
  typedef enum logic {
    wb_idle,
    wb_cycle
  } wb_state_t;

  ////////////////////
  // register map
  localparam bridge_addr_t addr_core_reset     = 32'h0000_0050;
  localparam bridge_addr_t addr_hide_overscan  = 32'h0000_0200;
  localparam bridge_addr_t addr_mask_edges     = 32'h0000_0204;
  localparam bridge_addr_t addr_extra_sprites  = 32'h0000_0208;
  localparam bridge_addr_t addr_palette        = 32'h0000_020C;
  localparam bridge_addr_t addr_multitap       = 32'h0000_0300;
  localparam bridge_addr_t addr_lightgun       = 32'h0000_0304;
  localparam bridge_addr_t addr_aim_speed      = 32'h0000_0308;
  localparam bridge_addr_t addr_swap           = 32'h0000_030C;

  ////////////////////
  // timing
  // must fit reset_count_t
  localparam int unsigned reset_hold_cycles = 64;
  // must fit hs_count_t
  localparam int unsigned hs_delay_cycles   = 7;
  // status word bit carrying hide overscan
  localparam int unsigned slot_flag_bit     = 13;

endpackage

`default_nettype wire

//--- logic/core_settings_top.sv
/*
  Top level of the settings and video path, all on clk_74a.
  pll_core_locked low holds everything in reset.
  Bridge requests must be at least four cycles apart.
*/
`timescale 1ns/1ps
`default_nettype none

module core_settings_top (
  input  wire                         clk_74a,
  input  wire                         pll_core_locked,

  // host bridge
  input  wire core_pkg::bridge_addr_t bridge_addr,
  input  wire                         bridge_rd,
  input  wire                         bridge_wr,
  input  wire core_pkg::bridge_data_t bridge_wr_data,
  output core_pkg::bridge_data_t      bridge_rd_data,

  // settings to the core
  output logic                        hide_overscan,
  output core_pkg::edge_mask_t        mask_vid_edges,
  output logic                        allow_extra_sprites,
  output core_pkg::palette_t          selected_palette,
  output logic                        multitap_enabled,
  output logic                        lightgun_enabled,
  output core_pkg::aim_speed_t        lightgun_aim_speed,
  output logic                        swap_controllers,
  output logic                        core_reset,

  // video from the core
  input  wire                         h_blank,
  input  wire                         v_blank,
  input  wire                         core_hs,
  input  wire                         core_vs,
  input  wire core_pkg::rgb_t         core_rgb,

  // video to the scaler
  output logic                        video_de,
  output logic                        video_hs,
  output logic                        video_vs,
  output core_pkg::rgb_t              video_rgb
);

  wb_if bus ();

  ////////////////////
  // control path

  bridge_master bridge_master_i (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge_addr     (bridge_addr),
    .bridge_rd       (bridge_rd),
    .bridge_wr       (bridge_wr),
    .bridge_wr_data  (bridge_wr_data),
    .bridge_rd_data  (bridge_rd_data),
    .bus             (bus.master)
  );

  settings_regs settings_regs_i (
    .clk_74a             (clk_74a),
    .pll_core_locked     (pll_core_locked),
    .bus                 (bus.slave),
    .hide_overscan       (hide_overscan),
    .mask_vid_edges      (mask_vid_edges),
    .allow_extra_sprites (allow_extra_sprites),
    .selected_palette    (selected_palette),
    .multitap_enabled    (multitap_enabled),
    .lightgun_enabled    (lightgun_enabled),
    .lightgun_aim_speed  (lightgun_aim_speed),
    .swap_controllers    (swap_controllers),
    .core_reset          (core_reset)
  );

  ////////////////////
  // video path

  // hide overscan also goes into the line-end status word
  video_conditioner video_conditioner_i (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .hide_overscan   (hide_overscan),
    .h_blank         (h_blank),
    .v_blank         (v_blank),
    .core_hs         (core_hs),
    .core_vs         (core_vs),
    .core_rgb        (core_rgb),
    .video_de        (video_de),
    .video_hs        (video_hs),
    .video_vs        (video_vs),
    .video_rgb       (video_rgb)
  );

endmodule

`default_nettype wire

//--- logic/settings_regs.sv
/*
  Wishbone slave holding the core settings and the core reset timer.
  Each field takes the low bits of the written word, reads are zero-extended.
  Unmapped addresses and the reset address read as zero.
  core_reset stays high for reset_hold_cycles after a reset write.
*/
`timescale 1ns/1ps
`default_nettype none

module settings_regs (
  input  wire                    clk_74a,
  input  wire                    pll_core_locked,
  wb_if.slave                    bus,
  output logic                   hide_overscan,
  output core_pkg::edge_mask_t   mask_vid_edges,
  output logic                   allow_extra_sprites,
  output core_pkg::palette_t     selected_palette,
  output logic                   multitap_enabled,
  output logic                   lightgun_enabled,
  output core_pkg::aim_speed_t   lightgun_aim_speed,
  output logic                   swap_controllers,
  output logic                   core_reset
);

  core_pkg::reset_count_t reset_count;
  core_pkg::bridge_data_t rd_mux;
  logic                   access;
  logic                   wr_en;

  // new strobe, not the tail of the cycle we already acked
  assign access = bus.cyc && bus.stb && !bus.ack;
  assign wr_en  = access && bus.we;

  assign core_reset = (reset_count != '0);

  ////////////////////
  // read-back mux

  always_comb begin
    case (bus.adr)
      core_pkg::addr_hide_overscan: rd_mux = core_pkg::bridge_data_t'(hide_overscan);
      core_pkg::addr_mask_edges:    rd_mux = core_pkg::bridge_data_t'(mask_vid_edges);
      core_pkg::addr_extra_sprites: rd_mux = core_pkg::bridge_data_t'(allow_extra_sprites);
      core_pkg::addr_palette:       rd_mux = core_pkg::bridge_data_t'(selected_palette);
      core_pkg::addr_multitap:      rd_mux = core_pkg::bridge_data_t'(multitap_enabled);
      core_pkg::addr_lightgun:      rd_mux = core_pkg::bridge_data_t'(lightgun_enabled);
      core_pkg::addr_aim_speed:     rd_mux = core_pkg::bridge_data_t'(lightgun_aim_speed);
      core_pkg::addr_swap:          rd_mux = core_pkg::bridge_data_t'(swap_controllers);
      default:                      rd_mux = '0;
    endcase
  end

  ////////////////////
  // settings, reset timer and ack

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      bus.ack             <= 1'b0;
      reset_count         <= '0;
      hide_overscan       <= 1'b0;
      mask_vid_edges      <= '0;
      allow_extra_sprites <= 1'b0;
      selected_palette    <= '0;
      multitap_enabled    <= 1'b0;
      lightgun_enabled    <= 1'b0;
      lightgun_aim_speed  <= '0;
      swap_controllers    <= 1'b0;
    end else begin
      bus.ack <= access;

      if (reset_count != '0) begin
        reset_count <= reset_count - 1'b1;
      end

      // a reset write below overrides the decrement
      if (wr_en) begin
        case (bus.adr)
          core_pkg::addr_core_reset:
            reset_count <= core_pkg::reset_count_t'(core_pkg::reset_hold_cycles);
          core_pkg::addr_hide_overscan: hide_overscan       <= bus.dat_w[0];
          core_pkg::addr_mask_edges:    mask_vid_edges      <= core_pkg::edge_mask_t'(bus.dat_w);
          core_pkg::addr_extra_sprites: allow_extra_sprites <= bus.dat_w[0];
          core_pkg::addr_palette:       selected_palette    <= core_pkg::palette_t'(bus.dat_w);
          core_pkg::addr_multitap:      multitap_enabled    <= bus.dat_w[0];
          core_pkg::addr_lightgun:      lightgun_enabled    <= bus.dat_w[0];
          core_pkg::addr_aim_speed:     lightgun_aim_speed  <= core_pkg::aim_speed_t'(bus.dat_w);
          core_pkg::addr_swap:          swap_controllers    <= bus.dat_w[0];
          default: ;
        endcase
      end
    end
  end

  // read data lines up with ack
  always_ff @(posedge clk_74a) begin
    if (access) begin
      bus.dat_r <= rd_mux;
    end
  end

endmodule

`default_nettype wire

//--- logic/video_conditioner.sv
/*
  Conditions the core video for the scaler, one cycle of latency on every output.
  HSync is moved hs_delay_cycles later so it never lands on the VSync pulse.
  A new HSync rise restarts the delay, and a pulse already due still fires.
*/
`timescale 1ns/1ps
`default_nettype none

module video_conditioner (
  input  wire                 clk_74a,
  input  wire                 pll_core_locked,
  input  wire                 hide_overscan,
  input  wire                 h_blank,
  input  wire                 v_blank,
  input  wire                 core_hs,
  input  wire                 core_vs,
  input  wire core_pkg::rgb_t core_rgb,
  output logic                video_de,
  output logic                video_hs,
  output logic                video_vs,
  output core_pkg::rgb_t      video_rgb
);

  logic                de;
  logic                de_prev;
  logic                hs_prev;
  logic                vs_prev;
  core_pkg::hs_count_t hs_count;
  core_pkg::rgb_t      status_word;

  assign de = !(h_blank || v_blank);

  // line-end status word, only the slot flag is set
  always_comb begin
    status_word = '0;
    status_word[core_pkg::slot_flag_bit] = hide_overscan;
  end

  ////////////////////
  // output registers

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_de  <= 1'b0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
      video_rgb <= '0;
      de_prev   <= 1'b0;
      hs_prev   <= 1'b0;
      vs_prev   <= 1'b0;
      hs_count  <= '0;
    end else begin
      video_de <= de;

      if (de) begin
        video_rgb <= core_rgb;
      end else if (de_prev) begin
        // first blank cycle after active video
        video_rgb <= status_word;
      end else begin
        video_rgb <= '0;
      end

      // one-cycle vsync on the rising edge
      video_vs <= core_vs && !vs_prev;

      // hsync delay line
      video_hs <= (hs_count == core_pkg::hs_count_t'(1));
      if (core_hs && !hs_prev) begin
        hs_count <= core_pkg::hs_count_t'(core_pkg::hs_delay_cycles);
      end else if (hs_count != '0) begin
        hs_count <= hs_count - 1'b1;
      end

      de_prev <= de;
      hs_prev <= core_hs;
      vs_prev <= core_vs;
    end
  end

endmodule

`default_nettype wire

//--- logic/wb_if.sv
/*
  Wishbone classic bundle between the bridge master and the settings block.
  No clock inside, both ends run on clk_74a.
  One outstanding cycle at a time, no burst or error signals.
*/
`timescale 1ns/1ps
`default_nettype none

interface wb_if;

  logic                     cyc;
  logic                     stb;
  logic                     we;
  core_pkg::bridge_addr_t   adr;
  core_pkg::bridge_data_t   dat_w;
  core_pkg::bridge_data_t   dat_r;
  logic                     ack;

  modport master (
    output cyc, stb, we, adr, dat_w,
    input  dat_r, ack
  );

  modport slave (
    input  cyc, stb, we, adr, dat_w,
    output dat_r, ack
  );

endinterface

`default_nettype wire

//--- sim.f
logic/core_pkg.sv
logic/wb_if.sv
logic/bridge_master.sv
logic/settings_regs.sv
logic/video_conditioner.sv
logic/core_settings_top.sv
verif/core_settings_assertions.sv
verif/tb_core_settings.sv

//--- verif/core_settings_assertions.sv
/*
  Bus handshake and sync pulse rules, bound into core_settings_top.
  All properties are disabled while pll_core_locked is low.
  fail_count is read by the testbench at the end of the run.
*/
`timescale 1ns/1ps
`default_nettype none

module core_settings_assertions (
  input wire clk_74a,
  input wire pll_core_locked,
  input wire cyc,
  input wire stb,
  input wire ack,
  input wire video_hs,
  input wire video_vs
);

  int fail_count = 0;

  ////////////////////
  // wishbone handshake

  ack_in_cycle: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    ack |-> (cyc && stb))
    else begin
      $error("ack raised outside a bus cycle");
      fail_count++;
    end

  ack_single: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    ack |=> !ack)
    else begin
      $error("ack held for two cycles");
      fail_count++;
    end

  ////////////////////
  // sync pulses

  hs_single: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_hs |=> !video_hs)
    else begin
      $error("video_hs high two cycles running");
      fail_count++;
    end

  vs_single: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_vs |=> !video_vs)
    else begin
      $error("video_vs high two cycles running");
      fail_count++;
    end

endmodule

bind core_settings_top core_settings_assertions core_settings_assertions_i (
  .clk_74a         (clk_74a),
  .pll_core_locked (pll_core_locked),
  .cyc             (bus.cyc),
  .stb             (bus.stb),
  .ack             (bus.ack),
  .video_hs        (video_hs),
  .video_vs        (video_vs)
);

`default_nettype wire

//--- verif/tb_core_settings.sv
/*
  Random stimulus from seed 77 against a cycle model of the bridge and video rules.
  Outputs are checked 1 ns after each rising edge, before new inputs are driven.
  Video writes happen only while the video inputs are blanked.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_core_settings;

  logic clk_74a;
  logic pll_core_locked;
  core_pkg::bridge_addr_t bridge_addr;
  logic bridge_rd;
  logic bridge_wr;
  core_pkg::bridge_data_t bridge_wr_data;
  core_pkg::bridge_data_t bridge_rd_data;
  logic hide_overscan;
  core_pkg::edge_mask_t mask_vid_edges;
  logic allow_extra_sprites;
  core_pkg::palette_t selected_palette;
  logic multitap_enabled;
  logic lightgun_enabled;
  core_pkg::aim_speed_t lightgun_aim_speed;
  logic swap_controllers;
  logic core_reset;
  logic h_blank;
  logic v_blank;
  logic core_hs;
  logic core_vs;
  core_pkg::rgb_t core_rgb;
  logic video_de;
  logic video_hs;
  logic video_vs;
  core_pkg::rgb_t video_rgb;

  int seed;
  int errors;
  int timeouts;
  int cycle;
  int i;
  int j;
  int hold;
  core_pkg::bridge_data_t data;

  // register model in register map order
  core_pkg::bridge_addr_t reg_addr [8];
  core_pkg::bridge_data_t reg_mask [8];
  core_pkg::bridge_data_t exp_reg [8];

  // video model state
  logic m_de_prev;
  logic m_hs_prev;
  logic m_vs_prev;
  int hs_due [$];

  core_settings_top core_settings_top_i (.*);

  initial begin
    clk_74a = 1'b0;
    forever #2 clk_74a = ~clk_74a;
  end

  initial begin
    #100000;
    $display("watchdog expired before the test sequence finished");
    $display("TESTS FAILED");
    $finish;
  end

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      errors = errors + 1;
    end
  endtask

  function automatic core_pkg::bridge_data_t setting_value(input int idx);
    case (idx)
      0: setting_value = hide_overscan;
      1: setting_value = mask_vid_edges;
      2: setting_value = allow_extra_sprites;
      3: setting_value = selected_palette;
      4: setting_value = multitap_enabled;
      5: setting_value = lightgun_enabled;
      6: setting_value = lightgun_aim_speed;
      default: setting_value = swap_controllers;
    endcase
  endfunction

  ////////////////////
  // one clock with video model check

  task automatic step_cycle();
    logic exp_de;
    logic exp_hs;
    logic exp_vs;
    core_pkg::rgb_t exp_rgb;
    @(posedge clk_74a);
    cycle = cycle + 1;
    #1;
    // inputs still hold the values sampled at this edge
    exp_de = !(h_blank || v_blank);
    exp_rgb = '0;
    if (exp_de) begin
      exp_rgb = core_rgb;
    end else if (m_de_prev) begin
      exp_rgb[core_pkg::slot_flag_bit] = exp_reg[0][0];
    end
    exp_vs = core_vs && !m_vs_prev;
    exp_hs = (hs_due.size() > 0) && (hs_due[0] == cycle);
    if (exp_hs) begin
      void'(hs_due.pop_front());
    end
    // new rise cancels any pending pulse
    if (core_hs && !m_hs_prev) begin
      hs_due.delete();
      hs_due.push_back(cycle + 7);
    end
    compare_value("video_de", exp_de, video_de);
    compare_value("video_rgb", exp_rgb, video_rgb);
    compare_value("video_vs", exp_vs, video_vs);
    compare_value("video_hs", exp_hs, video_hs);
    m_de_prev = exp_de;
    m_hs_prev = core_hs;
    m_vs_prev = core_vs;
  endtask

  ////////////////////
  // bridge requests

  task automatic bus_write(input core_pkg::bridge_addr_t addr, input core_pkg::bridge_data_t wd);
    bridge_addr = addr;
    bridge_wr_data = wd;
    bridge_wr = 1'b1;
    step_cycle();
    bridge_wr = 1'b0;
  endtask

  // read data checked 3 cycles after the pulse
  task automatic bus_read(input core_pkg::bridge_addr_t addr, input core_pkg::bridge_data_t exp);
    bridge_addr = addr;
    bridge_rd = 1'b1;
    step_cycle();
    bridge_rd = 1'b0;
    repeat (2) step_cycle();
    compare_value($sformatf("read %h", addr), exp, bridge_rd_data);
    // one more cycle keeps the next request spaced
    step_cycle();
  endtask

  task automatic video_stream(input int cycles);
    int k;
    for (k = 0; k < cycles; k++) begin
      h_blank = ($unsigned($random(seed)) % 3) == 0;
      v_blank = ($unsigned($random(seed)) % 16) == 0;
      core_rgb = core_pkg::rgb_t'($random(seed));
      if (($unsigned($random(seed)) % 10) == 0) begin
        core_hs = !core_hs;
      end
      if (($unsigned($random(seed)) % 12) == 0) begin
        core_vs = !core_vs;
      end
      step_cycle();
    end
    // blank again so later writes never meet a line end
    h_blank = 1'b1;
    v_blank = 1'b1;
    core_rgb = '0;
    step_cycle();
  endtask

  initial begin
    seed = 77;
    errors = 0;
    timeouts = 0;
    cycle = 0;
    pll_core_locked = 1'b0;
    bridge_addr = '0;
    bridge_rd = 1'b0;
    bridge_wr = 1'b0;
    bridge_wr_data = '0;
    h_blank = 1'b1;
    v_blank = 1'b1;
    core_hs = 1'b0;
    core_vs = 1'b0;
    core_rgb = '0;
    m_de_prev = 1'b0;
    m_hs_prev = 1'b0;
    m_vs_prev = 1'b0;
    reg_addr = '{core_pkg::addr_hide_overscan, core_pkg::addr_mask_edges,
                 core_pkg::addr_extra_sprites, core_pkg::addr_palette,
                 core_pkg::addr_multitap, core_pkg::addr_lightgun,
                 core_pkg::addr_aim_speed, core_pkg::addr_swap};
    reg_mask = '{32'h1, 32'h3, 32'h1, 32'h7, 32'h1, 32'h1, 32'hFF, 32'h1};
    for (i = 0; i < 8; i++) begin
      exp_reg[i] = '0;
    end

    repeat (16) @(posedge clk_74a);
    #1;
    pll_core_locked = 1'b1;

    // reset values
    compare_value("reset bridge_rd_data", 0, bridge_rd_data);
    compare_value("reset core_reset", 0, core_reset);
    compare_value("reset video_de", 0, video_de);
    compare_value("reset video_hs", 0, video_hs);
    compare_value("reset video_vs", 0, video_vs);
    compare_value("reset video_rgb", 0, video_rgb);
    for (i = 0; i < 8; i++) begin
      compare_value($sformatf("reset setting %0d", i), 0, setting_value(i));
    end
    step_cycle();

    ////////////////////
    // random settings writes and read-back
    repeat (40) begin
      i = $unsigned($random(seed)) % 8;
      data = $random(seed);
      bus_write(reg_addr[i], data);
      exp_reg[i] = data & reg_mask[i];
      repeat (3) step_cycle();
      for (j = 0; j < 8; j++) begin
        compare_value($sformatf("setting %0d", j), exp_reg[j], setting_value(j));
      end
    end
    for (i = 0; i < 8; i++) begin
      bus_read(reg_addr[i], exp_reg[i]);
    end
    repeat (8) begin
      bus_read(32'h400 + 4 * ($unsigned($random(seed)) % 64), 0);
    end
    bus_read(core_pkg::addr_core_reset, 0);

    ////////////////////
    // core reset hold
    bus_write(core_pkg::addr_core_reset, $random(seed));
    hold = 1;
    while (!core_reset && hold < 10) begin
      step_cycle();
      hold = hold + 1;
    end
    if (!core_reset) begin
      $display("core_reset never rose after the reset write");
      timeouts = timeouts + 1;
    end else begin
      compare_value("core_reset delay", 2, hold);
      hold = 0;
      while (core_reset && hold < 200) begin
        hold = hold + 1;
        step_cycle();
      end
      if (core_reset) begin
        $display("core_reset did not fall within 200 cycles");
        timeouts = timeouts + 1;
      end
      compare_value("core_reset length", core_pkg::reset_hold_cycles, hold);
    end

    // video with both status flag values
    bus_write(core_pkg::addr_hide_overscan, 32'h1);
    exp_reg[0] = 32'h1;
    repeat (3) step_cycle();
    video_stream(300);
    bus_write(core_pkg::addr_hide_overscan, 32'h0);
    exp_reg[0] = 32'h0;
    repeat (3) step_cycle();
    video_stream(300);

    errors = errors + core_settings_top_i.core_settings_assertions_i.fail_count;
    $display("errors: checks=%0d timeouts=%0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
